/* src/frame_pkg.sv */
package frame_pkg;

    ////////////////////////////////////////
    // widths and framing constants

    localparam int BYTE_W      = 8;
    localparam int COORD_W     = 16;
    localparam int ADDR_W      = 16;
    localparam int DATA_W      = 32;
    localparam int CMD_BYTES   = (ADDR_W + DATA_W) / BYTE_W;
    localparam int MAGIC_BYTES = 8;

    // spells BIVFRAME, sent from the top byte down
    localparam logic [MAGIC_BYTES*BYTE_W-1:0] MAGIC_NUM = 64'h42_49_56_46_52_41_4D_45;

    ////////////////////////////////////////
    // bundled signals

    typedef struct packed {
        logic              sof;
        logic [BYTE_W-1:0] ch0;
        logic [BYTE_W-1:0] ch1;
    } pixel_beat_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
    } command_t;

    typedef struct packed {
        logic [COORD_W-1:0] col_start;
        logic [COORD_W-1:0] row_start;
    } roi_corner_t;

    // host register map
    typedef enum logic [ADDR_W-1:0] {
        REG_COL_START = 16'h0010,
        REG_ROW_START = 16'h0011
    } reg_addr_e;

    typedef enum logic [1:0] {
        SER_IDLE,
        SER_HEADER,
        SER_CH0,
        SER_CH1
    } ser_state_e;

endpackage

/* src/command_assembler.sv */
`timescale 1ns/1ps

module command_assembler (
    input  logic                         core_clk,
    input  logic                         sys_reset,
    input  logic [frame_pkg::BYTE_W-1:0] cmd_byte_i,
    input  logic                         cmd_byte_valid_i,
    output frame_pkg::command_t          cmd_o,
    output logic                         cmd_valid_o
);
    import frame_pkg::*;

    localparam int CNT_W = $clog2(CMD_BYTES);
    localparam int CMD_W = $bits(command_t);

    logic [CNT_W-1:0] byte_cnt;
    logic [CMD_W-1:0] shift_q;
    logic             last_byte;

    // sixth byte of the word
    assign last_byte = cmd_byte_valid_i && (byte_cnt == CNT_W'(CMD_BYTES - 1));

    // address first, msb first, so older bytes end up on top
    always_ff @(posedge core_clk) begin
        if (cmd_byte_valid_i) begin
            shift_q <= {shift_q[CMD_W-BYTE_W-1:0], cmd_byte_i};
        end
    end

    always_ff @(posedge core_clk) begin
        if (sys_reset) begin
            byte_cnt    <= '0;
            cmd_valid_o <= 1'b0;
        end else begin
            cmd_valid_o <= last_byte;
            if (last_byte) begin
                byte_cnt <= '0;
            end else if (cmd_byte_valid_i) begin
                byte_cnt <= byte_cnt + CNT_W'(1);
            end
        end
    end

    assign cmd_o = command_t'(shift_q);

    // a word takes six strobes so pulses never touch
    cmd_valid_single_a: assert property (
        @(posedge core_clk) disable iff (sys_reset)
        cmd_valid_o |=> !cmd_valid_o
    );

endmodule

/* src/roi_regs.sv */
`timescale 1ns/1ps

module roi_regs #(
    parameter int unsigned DEFAULT_COL_START = 64,
    parameter int unsigned DEFAULT_ROW_START = 0
) (
    input  logic                   core_clk,
    input  logic                   sys_reset,
    input  frame_pkg::command_t    cmd_i,
    input  logic                   cmd_valid_i,
    output frame_pkg::roi_corner_t corner_o
);
    import frame_pkg::*;

    reg_addr_e          cmd_addr;
    logic [COORD_W-1:0] cmd_value;
    logic [COORD_W-1:0] col_start_q;
    logic [COORD_W-1:0] row_start_q;

    ////////////////////////////////////////
    // command decode

    assign cmd_addr  = reg_addr_e'(cmd_i.addr);
    assign cmd_value = cmd_i.data[COORD_W-1:0];

    ////////////////////////////////////////
    // corner registers

    always_ff @(posedge core_clk) begin
        if (sys_reset) begin
            col_start_q <= COORD_W'(DEFAULT_COL_START);
            row_start_q <= COORD_W'(DEFAULT_ROW_START);
        end else if (cmd_valid_i) begin
            case (cmd_addr)
                REG_COL_START: begin
                    col_start_q <= cmd_value;
                end
                REG_ROW_START: begin
                    row_start_q <= cmd_value;
                end
                default: begin
                    // unknown address, nothing to update
                end
            endcase
        end
    end

    always_comb begin
        corner_o.col_start = col_start_q;
        corner_o.row_start = row_start_q;
    end

endmodule

/* src/roi_cropper.sv */
`timescale 1ns/1ps

module roi_cropper #(
    parameter int unsigned RAW_WIDTH  = 640,
    parameter int unsigned RAW_HEIGHT = 480,
    parameter int unsigned ROI_WIDTH  = 512,
    parameter int unsigned ROI_HEIGHT = 480
) (
    input  logic                   core_clk,
    input  logic                   sys_reset,
    input  frame_pkg::pixel_beat_t pix_i,
    input  logic                   pix_valid_i,
    input  frame_pkg::roi_corner_t corner_i,
    output frame_pkg::pixel_beat_t roi_pix_o,
    output logic                   roi_valid_o
);
    import frame_pkg::*;

    logic [COORD_W-1:0] col_q;
    logic [COORD_W-1:0] row_q;
    logic [COORD_W-1:0] cur_col;
    logic [COORD_W-1:0] cur_row;
    roi_corner_t        corner_q;
    roi_corner_t        corner_sel;
    logic [COORD_W:0]   col_end;
    logic [COORD_W:0]   row_end;
    logic               col_last;
    logic               row_last;
    logic               in_window;
    logic               at_corner;

    ////////////////////////////////////////
    // position of the current beat

    // sof forces the origin and picks up a fresh corner
    always_comb begin
        cur_col    = pix_i.sof ? '0 : col_q;
        cur_row    = pix_i.sof ? '0 : row_q;
        corner_sel = pix_i.sof ? corner_i : corner_q;
    end

    assign col_last = (cur_col == COORD_W'(RAW_WIDTH - 1));
    assign row_last = (cur_row == COORD_W'(RAW_HEIGHT - 1));

    // window bounds, one bit wider so the end cannot wrap
    assign col_end = {1'b0, corner_sel.col_start} + (COORD_W + 1)'(ROI_WIDTH);
    assign row_end = {1'b0, corner_sel.row_start} + (COORD_W + 1)'(ROI_HEIGHT);

    assign in_window = (cur_col >= corner_sel.col_start) && ({1'b0, cur_col} < col_end) &&
                       (cur_row >= corner_sel.row_start) && ({1'b0, cur_row} < row_end);
    assign at_corner = (cur_col == corner_sel.col_start) && (cur_row == corner_sel.row_start);

    always_ff @(posedge core_clk) begin
        if (sys_reset) begin
            col_q    <= '0;
            row_q    <= '0;
            corner_q <= corner_i;
        end else if (pix_valid_i) begin
            corner_q <= corner_sel;
            if (col_last) begin
                col_q <= '0;
                row_q <= row_last ? '0 : cur_row + COORD_W'(1);
            end else begin
                col_q <= cur_col + COORD_W'(1);
                row_q <= cur_row;
            end
        end
    end

    ////////////////////////////////////////
    // kept beats

    always_ff @(posedge core_clk) begin
        if (sys_reset) begin
            roi_valid_o <= 1'b0;
        end else begin
            roi_valid_o <= pix_valid_i && in_window;
        end
    end

    always_ff @(posedge core_clk) begin
        if (pix_valid_i && in_window) begin
            roi_pix_o.sof <= at_corner;
            roi_pix_o.ch0 <= pix_i.ch0;
            roi_pix_o.ch1 <= pix_i.ch1;
        end
    end

    raw_row_bound_a: assert property (
        @(posedge core_clk) disable iff (sys_reset)
        row_q < COORD_W'(RAW_HEIGHT)
    );

endmodule

/* src/pixel_fifo.sv */
`timescale 1ns/1ps

module pixel_fifo #(
    parameter int unsigned FIFO_DEPTH = 1024
) (
    input  logic                   core_clk,
    input  logic                   sys_reset,
    input  frame_pkg::pixel_beat_t wr_beat_i,
    input  logic                   wr_valid_i,
    output frame_pkg::pixel_beat_t rd_beat_o,
    output logic                   not_empty_o,
    input  logic                   pop_i,
    output logic                   overflow_o
);
    import frame_pkg::*;

    localparam int AW = $clog2(FIFO_DEPTH);

    pixel_beat_t mem [FIFO_DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic          full;
    logic          do_write;
    logic          do_read;

    assign full     = (count == (AW + 1)'(FIFO_DEPTH));
    assign do_write = wr_valid_i && !full;
    assign do_read  = pop_i && not_empty_o;

    ////////////////////////////////////////
    // storage

    always_ff @(posedge core_clk) begin
        if (do_write) begin
            mem[wr_ptr] <= wr_beat_i;
        end
    end

    // show-ahead head
    assign rd_beat_o   = mem[rd_ptr];
    assign not_empty_o = (count != '0);

    ////////////////////////////////////////
    // pointers and occupancy

    // pointers wrap on their own since the depth is a power of two
    always_ff @(posedge core_clk) begin
        if (sys_reset) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            overflow_o <= 1'b0;
        end else begin
            if (do_write) begin
                wr_ptr <= wr_ptr + AW'(1);
            end
            if (do_read) begin
                rd_ptr <= rd_ptr + AW'(1);
            end
            case ({do_write, do_read})
                2'b10:   count <= count + (AW + 1)'(1);
                2'b01:   count <= count - (AW + 1)'(1);
                default: count <= count;
            endcase
            // sticky until reset
            if (wr_valid_i && full) begin
                overflow_o <= 1'b1;
            end
        end
    end

    // the serializer only pops what it was shown
    pop_not_empty_a: assert property (
        @(posedge core_clk) disable iff (sys_reset)
        pop_i |-> not_empty_o
    );

endmodule

/* src/frame_serializer.sv */
`timescale 1ns/1ps

module frame_serializer (
    input  logic                         core_clk,
    input  logic                         sys_reset,
    input  frame_pkg::pixel_beat_t       beat_i,
    input  logic                         beat_avail_i,
    output logic                         pop_o,
    input  logic                         tx_stall_i,
    output logic [frame_pkg::BYTE_W-1:0] tx_byte_o,
    output logic                         tx_valid_o
);
    import frame_pkg::*;

    localparam int IDX_W = $clog2(MAGIC_BYTES);

    ser_state_e       state;
    ser_state_e       next_beat_state;
    logic [IDX_W-1:0] hdr_idx;
    pixel_beat_t      beat_q;
    logic [BYTE_W-1:0] hdr_byte;

    // take a beat when idle or right after the last byte of the previous one
    assign pop_o = beat_avail_i &&
                   ((state == SER_IDLE) || ((state == SER_CH1) && !tx_stall_i));

    // a frame start needs the magic header first
    assign next_beat_state = beat_i.sof ? SER_HEADER : SER_CH0;

    // header walks down from the top byte
    assign hdr_byte = MAGIC_NUM[(MAGIC_BYTES - 1 - int'(hdr_idx)) * BYTE_W +: BYTE_W];

    always_ff @(posedge core_clk) begin
        if (pop_o) begin
            beat_q <= beat_i;
        end
    end

    ////////////////////////////////////////
    // byte sequencing

    always_ff @(posedge core_clk) begin
        if (sys_reset) begin
            state      <= SER_IDLE;
            hdr_idx    <= '0;
            tx_valid_o <= 1'b0;
            tx_byte_o  <= '0;
        end else begin
            tx_valid_o <= 1'b0;
            case (state)
                SER_IDLE: begin
                    hdr_idx <= '0;
                    if (pop_o) begin
                        state <= next_beat_state;
                    end
                end
                SER_HEADER: begin
                    if (!tx_stall_i) begin
                        tx_valid_o <= 1'b1;
                        tx_byte_o  <= hdr_byte;
                        hdr_idx    <= hdr_idx + IDX_W'(1);
                        if (hdr_idx == IDX_W'(MAGIC_BYTES - 1)) begin
                            state <= SER_CH0;
                        end
                    end
                end
                SER_CH0: begin
                    if (!tx_stall_i) begin
                        tx_valid_o <= 1'b1;
                        tx_byte_o  <= beat_q.ch0;
                        state      <= SER_CH1;
                    end
                end
                SER_CH1: begin
                    if (!tx_stall_i) begin
                        tx_valid_o <= 1'b1;
                        tx_byte_o  <= beat_q.ch1;
                        hdr_idx    <= '0;
                        state      <= pop_o ? next_beat_state : SER_IDLE;
                    end
                end
                default: begin
                    state <= SER_IDLE;
                end
            endcase
        end
    end

    // a sampled stall blanks the next cycle
    stall_blanks_a: assert property (
        @(posedge core_clk) disable iff (sys_reset)
        tx_stall_i |=> !tx_valid_o
    );

endmodule

/* src/frame_link_top.sv */
`timescale 1ns/1ps

module frame_link_top #(
    parameter int unsigned RAW_WIDTH         = 640,
    parameter int unsigned RAW_HEIGHT        = 480,
    parameter int unsigned ROI_WIDTH         = 512,
    parameter int unsigned ROI_HEIGHT        = 480,
    parameter int unsigned DEFAULT_COL_START = 64,
    parameter int unsigned DEFAULT_ROW_START = 0,
    parameter int unsigned FIFO_DEPTH        = 1024
) (
    input  logic                         core_clk,
    input  logic                         sys_reset,
    input  frame_pkg::pixel_beat_t       pix_i,
    input  logic                         pix_valid_i,
    input  logic [frame_pkg::BYTE_W-1:0] cmd_byte_i,
    input  logic                         cmd_byte_valid_i,
    input  logic                         tx_stall_i,
    output logic [frame_pkg::BYTE_W-1:0] tx_byte_o,
    output logic                         tx_valid_o,
    output logic                         overflow_o
);
    import frame_pkg::*;

    command_t    cmd;
    logic        cmd_valid;
    roi_corner_t corner;
    pixel_beat_t roi_pix;
    logic        roi_valid;
    pixel_beat_t head_beat;
    logic        head_avail;
    logic        pop;

    ////////////////////////////////////////
    // host command path

    command_assembler command_assembler_i (
        .core_clk        (core_clk),
        .sys_reset       (sys_reset),
        .cmd_byte_i      (cmd_byte_i),
        .cmd_byte_valid_i(cmd_byte_valid_i),
        .cmd_o           (cmd),
        .cmd_valid_o     (cmd_valid)
    );

    roi_regs #(
        .DEFAULT_COL_START(DEFAULT_COL_START),
        .DEFAULT_ROW_START(DEFAULT_ROW_START)
    ) roi_regs_i (
        .core_clk   (core_clk),
        .sys_reset  (sys_reset),
        .cmd_i      (cmd),
        .cmd_valid_i(cmd_valid),
        .corner_o   (corner)
    );

    ////////////////////////////////////////
    // frame path

    roi_cropper #(
        .RAW_WIDTH (RAW_WIDTH),
        .RAW_HEIGHT(RAW_HEIGHT),
        .ROI_WIDTH (ROI_WIDTH),
        .ROI_HEIGHT(ROI_HEIGHT)
    ) roi_cropper_i (
        .core_clk   (core_clk),
        .sys_reset  (sys_reset),
        .pix_i      (pix_i),
        .pix_valid_i(pix_valid_i),
        .corner_i   (corner),
        .roi_pix_o  (roi_pix),
        .roi_valid_o(roi_valid)
    );

    pixel_fifo #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) pixel_fifo_i (
        .core_clk   (core_clk),
        .sys_reset  (sys_reset),
        .wr_beat_i  (roi_pix),
        .wr_valid_i (roi_valid),
        .rd_beat_o  (head_beat),
        .not_empty_o(head_avail),
        .pop_i      (pop),
        .overflow_o (overflow_o)
    );

    frame_serializer frame_serializer_i (
        .core_clk    (core_clk),
        .sys_reset   (sys_reset),
        .beat_i      (head_beat),
        .beat_avail_i(head_avail),
        .pop_o       (pop),
        .tx_stall_i  (tx_stall_i),
        .tx_byte_o   (tx_byte_o),
        .tx_valid_o  (tx_valid_o)
    );

endmodule

/* bench/clock_gen.sv */
`timescale 1ns/1ps

module clock_gen #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 8
) (
    output logic clk_o,
    output logic reset_o
);

    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD_NS / 2);
            clk_o = ~clk_o;
        end
    end

    // release on a falling edge, away from the sampling edge
    initial begin
        reset_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        reset_o = 1'b0;
    end

endmodule

/* bench/frame_link_tb.sv */
`timescale 1ns/1ps

module frame_link_tb;
    import frame_pkg::*;

    localparam int PERIOD_NS   = 100;
    localparam int RAW_W       = 12;
    localparam int RAW_H       = 6;
    localparam int ROI_W       = 8;
    localparam int ROI_H       = 4;
    localparam int DEF_COL     = 2;
    localparam int DEF_ROW     = 1;
    localparam int FRAME_BEATS = RAW_W * RAW_H;
    // seven frames, each bounded by two pixel cycles per beat plus drain time
    localparam int NUM_FRAMES  = 7;
    localparam int FRAME_BOUND = 4 * FRAME_BEATS;
    localparam int SETUP_BOUND = 300;
    localparam longint WATCHDOG_NS = longint'(NUM_FRAMES * FRAME_BOUND + SETUP_BOUND) * PERIOD_NS;

    typedef enum logic [1:0] {STALL_OFF, STALL_RANDOM, STALL_HELD} stall_mode_e;

    logic              core_clk;
    logic              por_reset;
    logic              tb_reset;
    logic              sys_reset;
    pixel_beat_t       pix_i;
    logic              pix_valid_i;
    logic [BYTE_W-1:0] cmd_byte_i;
    logic              cmd_byte_valid_i;
    logic              tx_stall_i;
    logic [BYTE_W-1:0] tx_byte_o;
    logic              tx_valid_o;
    logic              overflow_o;

    stall_mode_e       stall_mode;
    logic [BYTE_W-1:0] exp_q [$];
    logic [BYTE_W-1:0] exp_head;
    logic              exp_pending;
    logic              check_bytes;
    logic              quiet_phase;
    logic              overflow_allowed;
    logic [BYTE_W-1:0] frame_ch0 [FRAME_BEATS];
    logic [BYTE_W-1:0] frame_ch1 [FRAME_BEATS];
    int                model_col;
    int                model_row;
    int                value_errors;
    int                other_errors;
    int unsigned       seed_ret;

    assign sys_reset = por_reset || tb_reset;

    clock_gen #(.PERIOD_NS(PERIOD_NS), .RESET_CYCLES(8)) clock_gen_i (
        .clk_o  (core_clk),
        .reset_o(por_reset)
    );

    frame_link_top #(
        .RAW_WIDTH        (RAW_W),
        .RAW_HEIGHT       (RAW_H),
        .ROI_WIDTH        (ROI_W),
        .ROI_HEIGHT       (ROI_H),
        .DEFAULT_COL_START(DEF_COL),
        .DEFAULT_ROW_START(DEF_ROW),
        .FIFO_DEPTH       (16)
    ) frame_link_top_i (
        .core_clk        (core_clk),
        .sys_reset       (sys_reset),
        .pix_i           (pix_i),
        .pix_valid_i     (pix_valid_i),
        .cmd_byte_i      (cmd_byte_i),
        .cmd_byte_valid_i(cmd_byte_valid_i),
        .tx_stall_i      (tx_stall_i),
        .tx_byte_o       (tx_byte_o),
        .tx_valid_o      (tx_valid_o),
        .overflow_o      (overflow_o)
    );

    task automatic report_mismatch(input string msg);
        value_errors++;
        $display("Fail at %0d ns: %s", $time, msg);
    endtask

    task automatic report_problem(input string msg);
        other_errors++;
        $display("Error at %0d ns: %s", $time, msg);
    endtask

    ////////////////////////////////////////
    // expected byte tracking

    // head moves on once a byte has been seen
    always @(posedge core_clk) begin
        if (tx_valid_o && check_bytes && exp_q.size() > 0) begin
            void'(exp_q.pop_front());
        end
        exp_pending <= (exp_q.size() > 0);
        exp_head    <= (exp_q.size() > 0) ? exp_q[0] : '0;
    end

    byte_value_a: assert property (@(posedge core_clk) disable iff (sys_reset)
        (tx_valid_o && check_bytes && exp_pending) |-> (tx_byte_o == exp_head))
        else report_mismatch($sformatf("link byte %02h, expected %02h",
                                       $sampled(tx_byte_o), $sampled(exp_head)));

    no_extra_byte_a: assert property (@(posedge core_clk) disable iff (sys_reset)
        (tx_valid_o && check_bytes) |-> exp_pending)
        else report_problem("a byte left the link when none was expected");

    stall_gap_a: assert property (@(posedge core_clk) disable iff (sys_reset)
        tx_stall_i |=> !tx_valid_o)
        else report_problem("a byte left the link right after a sampled stall");

    quiet_a: assert property (@(posedge core_clk) disable iff (sys_reset)
        quiet_phase |-> !tx_valid_o)
        else report_problem("the link sent a byte with no pixel input");

    no_overflow_a: assert property (@(posedge core_clk) disable iff (sys_reset)
        !overflow_allowed |-> !overflow_o)
        else report_problem("overflow flag rose while the FIFO should keep up");

    overflow_sticky_a: assert property (@(posedge core_clk) disable iff (sys_reset)
        overflow_o |=> overflow_o)
        else report_problem("overflow flag dropped before reset");

    ////////////////////////////////////////
    // stimulus and reference model

    task automatic drive_stall();
        forever begin
            @(negedge core_clk);
            case (stall_mode)
                STALL_RANDOM: tx_stall_i = (($urandom % 4) == 0);
                STALL_HELD:   tx_stall_i = 1'b1;
                default:      tx_stall_i = 1'b0;
            endcase
        end
    endtask

    task automatic fill_frame();
        for (int i = 0; i < FRAME_BEATS; i++) begin
            frame_ch0[i] = BYTE_W'($urandom);
            frame_ch1[i] = BYTE_W'($urandom);
        end
    endtask

    // raster walk over the raw frame with the header in front of the corner beat
    task automatic build_expected();
        string magic;
        int    idx;
        magic = "BIVFRAME";
        for (int r = 0; r < RAW_H; r++) begin
            for (int c = 0; c < RAW_W; c++) begin
                if (c >= model_col && c < model_col + ROI_W &&
                    r >= model_row && r < model_row + ROI_H) begin
                    if (c == model_col && r == model_row) begin
                        for (int k = 0; k < 8; k++) begin
                            exp_q.push_back(magic[k]);
                        end
                    end
                    idx = r * RAW_W + c;
                    exp_q.push_back(frame_ch0[idx]);
                    exp_q.push_back(frame_ch1[idx]);
                end
            end
        end
    endtask

    task automatic send_frame();
        if (check_bytes) begin
            build_expected();
        end
        for (int i = 0; i < FRAME_BEATS; i++) begin
            @(negedge core_clk);
            pix_valid_i = 1'b1;
            pix_i.sof   = (i == 0);
            pix_i.ch0   = frame_ch0[i];
            pix_i.ch1   = frame_ch1[i];
            @(negedge core_clk);
            pix_valid_i = 1'b0;
        end
    endtask

    // address then data with the top byte first
    task automatic send_command(input logic [15:0] addr, input logic [31:0] data);
        logic [47:0] word;
        word = {addr, data};
        for (int i = 5; i >= 0; i--) begin
            @(negedge core_clk);
            cmd_byte_valid_i = 1'b1;
            cmd_byte_i       = word[i*8 +: 8];
            @(negedge core_clk);
            cmd_byte_valid_i = 1'b0;
        end
        if (addr == REG_COL_START) begin
            model_col = int'(data[15:0]);
        end else if (addr == REG_ROW_START) begin
            model_row = int'(data[15:0]);
        end
    endtask

    task automatic wait_drained();
        while (exp_q.size() > 0) begin
            @(negedge core_clk);
        end
        repeat (6) @(negedge core_clk);
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Error: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("Verification failed");
        $finish;
    end

    initial begin
        seed_ret         = $urandom(32'h14289a92);
        pix_i            = '0;
        pix_valid_i      = 1'b0;
        cmd_byte_i       = '0;
        cmd_byte_valid_i = 1'b0;
        tx_stall_i       = 1'b0;
        tb_reset         = 1'b0;
        stall_mode       = STALL_OFF;
        check_bytes      = 1'b1;
        quiet_phase      = 1'b0;
        overflow_allowed = 1'b0;
        model_col        = DEF_COL;
        model_row        = DEF_ROW;
        value_errors     = 0;
        other_errors     = 0;
        fork
            drive_stall();
        join_none
        @(negedge core_clk);
        while (sys_reset) begin
            @(negedge core_clk);
        end

        // idle link after reset
        quiet_phase = 1'b1;
        repeat (20) @(negedge core_clk);
        quiet_phase = 1'b0;

        // default window
        fill_frame();
        send_frame();
        wait_drained();

        // moved corner
        send_command(REG_COL_START, 32'h0000_0004);
        send_command(REG_ROW_START, 32'h0000_0002);
        fill_frame();
        send_frame();
        wait_drained();

        // unknown address leaves the window as it was
        send_command(16'h0012, 32'h0000_0001);
        fill_frame();
        send_frame();
        wait_drained();

        // same frame again under random stall and then a fresh one
        stall_mode = STALL_RANDOM;
        send_frame();
        wait_drained();
        fill_frame();
        send_frame();
        wait_drained();
        stall_mode = STALL_OFF;

        // link blocked for two frames
        check_bytes      = 1'b0;
        overflow_allowed = 1'b1;
        stall_mode       = STALL_HELD;
        fill_frame();
        send_frame();
        fill_frame();
        send_frame();
        assert (overflow_o) else report_problem("overflow flag did not rise under held stall");
        stall_mode = STALL_OFF;
        repeat (80) @(negedge core_clk);
        assert (overflow_o) else report_problem("overflow flag cleared without reset");
        tb_reset = 1'b1;
        repeat (8) @(negedge core_clk);
        tb_reset = 1'b0;
        overflow_allowed = 1'b0;
        @(negedge core_clk);
        assert (!overflow_o) else report_problem("overflow flag survived reset");
        repeat (4) @(negedge core_clk);

        $display("value errors: %0d, other errors: %0d", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

/* src.f */
src/frame_pkg.sv
src/command_assembler.sv
src/roi_regs.sv
src/roi_cropper.sv
src/pixel_fifo.sv
src/frame_serializer.sv
src/frame_link_top.sv
bench/clock_gen.sv
bench/frame_link_tb.sv

/* Bender.yml */
package:
  name: frame_link

sources:
  - files:
      - src/frame_pkg.sv
      - src/command_assembler.sv
      - src/roi_regs.sv
      - src/roi_cropper.sv
      - src/pixel_fifo.sv
      - src/frame_serializer.sv
      - src/frame_link_top.sv
  - target: test
    files:
      - bench/clock_gen.sv
      - bench/frame_link_tb.sv
